// File: source/user_area_pkg.sv
// User area package: bus types, region map, FIR register offsets and control word layout
package user_area_pkg;

    // Wishbone data, address and byte select
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  sel_t;

    // Address bits that pick a region
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 20;

    // Region bases, compared against adr[31:20]
    localparam logic [11:0] SRAM_REGION = 12'h380;
    localparam logic [11:0] FIR_REGION  = 12'h300;

    // FIR register offsets within the low 12 address bits
    localparam logic [11:0] OFF_AP_CTRL  = 12'h000;
    localparam logic [11:0] OFF_DATA_LEN = 12'h010;
    localparam logic [11:0] OFF_TAP_BASE = 12'h020;

    // Coefficient registers, one word each
    localparam int NUM_TAPS = 11;

    // Control word fields, bit 0 at the bottom
    typedef struct packed {
        logic [25:0] rsvd_hi;
        logic        y_ready;
        logic        x_ready;
        logic        rsvd3;
        logic        ap_idle;
        logic        ap_done;
        logic        ap_start;
    } ap_ctrl_fields_t;

    // Same 32-bit word as a raw bus value or as fields
    typedef union packed {
        word_t           raw;
        ap_ctrl_fields_t f;
    } ap_ctrl_u;

    // Only ap_start, ap_done and ap_idle are stored
    localparam int AP_CTRL_STORED = 3;

endpackage

// File: source/region_decoder.sv
// Region decoder: steers the bus request to one target and muxes its response back
module region_decoder (
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  user_area_pkg::addr_t  adr_i,
    output logic                  sram_req_o,
    output logic                  cfg_req_o,
    input  logic                  sram_ack_i,
    input  logic                  cfg_ack_i,
    input  user_area_pkg::word_t  sram_dat_i,
    input  user_area_pkg::word_t  cfg_dat_i,
    output logic                  ack_o,
    output user_area_pkg::word_t  dat_o
);
    import user_area_pkg::*;

    // Top address field
    logic [REGION_MSB-REGION_LSB:0] region;
    logic                           sram_hit;
    logic                           cfg_hit;
    logic                           bus_req;

    assign region = adr_i[REGION_MSB:REGION_LSB];

    // Bases differ, so at most one hit
    assign sram_hit = (region == SRAM_REGION);
    assign cfg_hit  = (region == FIR_REGION);

    // Valid Wishbone cycle
    assign bus_req = cyc_i && stb_i;

    always_comb begin
        // Unmapped space: no request, no ack, zero data
        sram_req_o = 1'b0;
        cfg_req_o  = 1'b0;
        ack_o      = 1'b0;
        dat_o      = '0;
        if (sram_hit) begin
            sram_req_o = bus_req;
            ack_o      = sram_ack_i;
            dat_o      = sram_dat_i;
        end else if (cfg_hit) begin
            cfg_req_o = bus_req;
            ack_o     = cfg_ack_i;
            dat_o     = cfg_dat_i;
        end
    end

endmodule

// File: source/user_sram.sv
// User memory: word array with byte-select writes and a delayed acknowledge
module user_sram #(
    parameter int WAIT_CYCLES = 10,
    parameter int SRAM_WORDS  = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  we_i,
    input  user_area_pkg::sel_t   sel_i,
    input  user_area_pkg::addr_t  adr_i,
    input  user_area_pkg::word_t  dat_i,
    output logic                  ack_o,
    output user_area_pkg::word_t  dat_o
);
    import user_area_pkg::*;

    // Room for counts 0..WAIT_CYCLES, also when WAIT_CYCLES is 0
    localparam int CNT_W = $clog2(WAIT_CYCLES + 2);
    localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

    word_t             mem [SRAM_WORDS];
    word_t             rd_q;
    logic [IDX_W-1:0]  word_idx;
    logic [CNT_W-1:0]  cnt_q;
    logic              ack_q;
    logic              fire;

    // Word index from the bits above the byte offset, wrapped to depth
    assign word_idx = IDX_W'((adr_i >> 2) % SRAM_WORDS);

    // Last wait cycle, the access completes on this edge
    assign fire = req_i && !ack_q && (cnt_q == CNT_W'(WAIT_CYCLES));

    // Wait counter and ack pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (!req_i) begin
                // Request dropped, start over
                cnt_q <= '0;
            end else if (fire) begin
                cnt_q <= '0;
                ack_q <= 1'b1;
            end else if (!ack_q) begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
        end
    end

    // Array access at the ack edge
    always_ff @(posedge clk) begin
        if (fire && we_i) begin
            for (int b = 0; b < 4; b++) begin
                // Only lanes with sel set
                if (sel_i[b]) begin
                    mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        if (fire) begin
            rd_q <= mem[word_idx];
        end
    end

    assign ack_o = ack_q;
    assign dat_o = rd_q;

endmodule

// File: source/fir_cfg_regs.sv
// FIR configuration bank: control, data length and tap registers with a delayed acknowledge
module fir_cfg_regs #(
    parameter int WAIT_CYCLES = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_i,
    input  logic                  we_i,
    input  user_area_pkg::addr_t  adr_i,
    input  user_area_pkg::word_t  dat_i,
    output logic                  ack_o,
    output user_area_pkg::word_t  dat_o
);
    import user_area_pkg::*;

    localparam int CNT_W     = $clog2(WAIT_CYCLES + 2);
    localparam int TAP_IDX_W = $clog2(NUM_TAPS);

    logic [11:0]               off;
    logic [11:0]               tap_off;
    logic [TAP_IDX_W-1:0]      tap_idx;
    logic                      ctrl_hit;
    logic                      len_hit;
    logic                      tap_hit;
    logic [AP_CTRL_STORED-1:0] ctrl_q;
    word_t                     len_q;
    word_t                     taps_q [NUM_TAPS];
    ap_ctrl_u                  ctrl_wr;
    ap_ctrl_u                  ctrl_rd;
    word_t                     rd_word;
    word_t                     rd_q;
    logic [CNT_W-1:0]          cnt_q;
    logic                      ack_q;
    logic                      fire;

    // Offset decode on the low 12 bits
    assign off      = adr_i[11:0];
    assign tap_off  = off - OFF_TAP_BASE;
    assign tap_idx  = TAP_IDX_W'(tap_off[11:2]);
    assign ctrl_hit = (off == OFF_AP_CTRL);
    assign len_hit  = (off == OFF_DATA_LEN);
    // Word-aligned and inside the coefficient window
    assign tap_hit  = (off >= OFF_TAP_BASE) && (tap_off[11:2] < 10'(NUM_TAPS))
                      && (tap_off[1:0] == 2'b00);

    // Incoming control word, seen as fields
    assign ctrl_wr.raw = dat_i;

    always_comb begin
        // No datapath, so the stream flags stay low
        ctrl_rd.raw        = '0;
        ctrl_rd.f.ap_start = ctrl_q[0];
        ctrl_rd.f.ap_done  = ctrl_q[1];
        ctrl_rd.f.ap_idle  = ctrl_q[2];
        ctrl_rd.f.x_ready  = 1'b0;
        ctrl_rd.f.y_ready  = 1'b0;
    end

    // Read mux, unmapped offsets give zero
    always_comb begin
        rd_word = '0;
        if (ctrl_hit) begin
            rd_word = ctrl_rd.raw;
        end else if (len_hit) begin
            rd_word = len_q;
        end else if (tap_hit) begin
            rd_word = taps_q[tap_idx];
        end
    end

    assign fire = req_i && !ack_q && (cnt_q == CNT_W'(WAIT_CYCLES));

    // Wait counter, ack pulse and register writes
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q  <= '0;
            ack_q  <= 1'b0;
            ctrl_q <= '0;
            len_q  <= '0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                taps_q[k] <= '0;
            end
        end else begin
            ack_q <= 1'b0;
            if (!req_i) begin
                cnt_q <= '0;
            end else if (fire) begin
                cnt_q <= '0;
                ack_q <= 1'b1;
            end else if (!ack_q) begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
            // Writes land at the ack edge
            if (fire && we_i) begin
                if (ctrl_hit) begin
                    ctrl_q <= {ctrl_wr.f.ap_idle, ctrl_wr.f.ap_done, ctrl_wr.f.ap_start};
                end else if (len_hit) begin
                    len_q <= dat_i;
                end else if (tap_hit) begin
                    taps_q[tap_idx] <= dat_i;
                end
            end
        end
    end

    // Read data captured with ack
    always_ff @(posedge clk) begin
        if (fire) begin
            rd_q <= rd_word;
        end
    end

    assign ack_o = ack_q;
    assign dat_o = rd_q;

endmodule

// File: source/user_area_top.sv
// User area top: Wishbone slave with region decode over user memory and FIR registers
module user_area_top #(
    parameter int WAIT_CYCLES = 10,
    parameter int SRAM_WORDS  = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  logic                  we_i,
    input  user_area_pkg::sel_t   sel_i,
    input  user_area_pkg::addr_t  adr_i,
    input  user_area_pkg::word_t  dat_i,
    output logic                  ack_o,
    output user_area_pkg::word_t  dat_o
);
    import user_area_pkg::*;

    // Per-target request and response
    logic  sram_req;
    logic  cfg_req;
    logic  sram_ack;
    logic  cfg_ack;
    word_t sram_dat;
    word_t cfg_dat;

    region_decoder u_decoder (
        .stb_i      (stb_i),
        .cyc_i      (cyc_i),
        .adr_i      (adr_i),
        .sram_req_o (sram_req),
        .cfg_req_o  (cfg_req),
        .sram_ack_i (sram_ack),
        .cfg_ack_i  (cfg_ack),
        .sram_dat_i (sram_dat),
        .cfg_dat_i  (cfg_dat),
        .ack_o      (ack_o),
        .dat_o      (dat_o)
    );

    // we, sel, adr and dat go to both targets as they are
    user_sram #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .SRAM_WORDS  (SRAM_WORDS)
    ) u_sram (
        .clk   (clk),
        .rst   (rst),
        .req_i (sram_req),
        .we_i  (we_i),
        .sel_i (sel_i),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .ack_o (sram_ack),
        .dat_o (sram_dat)
    );

    // Register bank ignores byte select
    fir_cfg_regs #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_cfg (
        .clk   (clk),
        .rst   (rst),
        .req_i (cfg_req),
        .we_i  (we_i),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .ack_o (cfg_ack),
        .dat_o (cfg_dat)
    );

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock source, free-running with a 4 ns period
module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Starts low, first rising edge at one half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

// File: dv/user_area_asserts.sv
// Bus protocol checks on the user area top level, attached by bind
module user_area_asserts (
    input logic clk,
    input logic rst,
    input logic stb_i,
    input logic cyc_i,
    input logic ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) ack_i |=> !ack_i
    ) else $error("ack_o stayed high for more than one cycle");

    // Ack answers a request that was on the bus at the previous edge
    ack_needs_stb: assert property (
        @(posedge clk) disable iff (rst) $rose(ack_i) |-> $past(stb_i && cyc_i)
    ) else $error("ack_o rose without an active stb_i");

    // Nothing acknowledged while reset is held
    ack_low_in_reset: assert property (
        @(posedge clk) rst |=> !ack_i
    ) else $error("ack_o high during reset");

endmodule

// File: dv/tb_user_area.sv
// Testbench for the user area: file-driven Wishbone accesses with read and latency checks
module tb_user_area;
    timeunit 1ns;
    timeprecision 1ps;
    import user_area_pkg::*;

    localparam int WAIT_CYCLES  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 4;

    logic  clk;
    logic  rst;
    logic  stb_i;
    logic  cyc_i;
    logic  we_i;
    sel_t  sel_i;
    addr_t adr_i;
    word_t dat_i;
    logic  ack_o;
    word_t dat_o;

    // Access list as read from the input file
    logic [7:0] op_q [$];
    addr_t      adr_q [$];
    word_t      wdat_q [$];
    sel_t       sel_q [$];
    word_t      exp_q [$];
    // Expected contents by bus address
    word_t      model [addr_t];
    int         err_count = 0;
    int         limit_ns = 0;

    tb_clock_gen u_clk (.clk_o(clk));

    user_area_top #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .SRAM_WORDS  (256)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .stb_i (stb_i),
        .cyc_i (cyc_i),
        .we_i  (we_i),
        .sel_i (sel_i),
        .adr_i (adr_i),
        .dat_i (dat_i),
        .ack_o (ack_o),
        .dat_o (dat_o)
    );

    bind user_area_top user_area_asserts u_asserts (
        .clk   (clk),
        .rst   (rst),
        .stb_i (stb_i),
        .cyc_i (cyc_i),
        .ack_i (ack_o)
    );

    task automatic abort_run(input string reason);
        err_count++;
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rdata(input addr_t adr, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] dat_o at adr_i=%h: expected %h, got %h", adr, expected, actual);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_latency(input addr_t adr, input int expected, input int actual);
        if (actual != expected) begin
            $display("[FAIL] ack_o latency at adr_i=%h: expected %0h edges, got %0h",
                     adr, expected, actual);
            abort_run("acknowledge latency mismatch");
        end
    endtask

    // Expected state after a write
    task automatic update_model(input addr_t adr, input word_t wdat, input sel_t sel);
        word_t    merged;
        ap_ctrl_u wr_view;
        ap_ctrl_u rd_view;
        if (adr[REGION_MSB:REGION_LSB] == SRAM_REGION) begin
            // Memory keeps the unselected bytes
            merged = model.exists(adr) ? model[adr] : '0;
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    merged[8*b +: 8] = wdat[8*b +: 8];
                end
            end
            model[adr] = merged;
        end else if (adr[11:0] == OFF_AP_CTRL) begin
            // Only start, done and idle survive
            wr_view.raw        = wdat;
            rd_view.raw        = '0;
            rd_view.f.ap_start = wr_view.f.ap_start;
            rd_view.f.ap_done  = wr_view.f.ap_done;
            rd_view.f.ap_idle  = wr_view.f.ap_idle;
            model[adr]         = rd_view.raw;
        end else begin
            model[adr] = wdat;
        end
    endtask

    // One Wishbone access, edges counts rising edges from stb up to ack
    task automatic bus_access(input logic we, input addr_t adr, input word_t wdat,
                              input sel_t sel, output word_t rdat, output int edges);
        @(negedge clk);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = wdat;
        sel_i = sel;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack_o !== 1'b1);
        rdat  = dat_o;
        stb_i = 1'b0;
        cyc_i = 1'b0;
        we_i  = 1'b0;
    endtask

    initial begin : main
        int         fd;
        int         n;
        int         edges;
        string      line;
        logic [7:0] op;
        addr_t      adr;
        word_t      wdat;
        sel_t       sel;
        word_t      expv;
        word_t      rdat;
        void'($urandom(32'h3155fe0e));
        rst   = 1'b1;
        stb_i = 1'b0;
        cyc_i = 1'b0;
        we_i  = 1'b0;
        sel_i = '0;
        adr_i = '0;
        dat_i = '0;
        fd = $fopen("dv/bus_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open dv/bus_input.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h", op, adr, wdat, sel, expv);
            if (n != 5) begin
                abort_run({"malformed line in input file: ", line});
            end
            op_q.push_back(op);
            adr_q.push_back(adr);
            wdat_q.push_back(wdat);
            sel_q.push_back(sel);
            exp_q.push_back(expv);
        end
        $fclose(fd);
        // Budget in ns, per access plus reset
        limit_ns = op_q.size() * (WAIT_CYCLES + 4) * CLK_PERIOD
                   + (RESET_CYCLES + 4) * CLK_PERIOD;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        foreach (op_q[i]) begin
            op  = op_q[i];
            adr = adr_q[i];
            if (op == "W" || op == "F") begin
                // Fill words are drawn here and kept in the model
                wdat = (op == "F") ? $urandom() : wdat_q[i];
                bus_access(1'b1, adr, wdat, sel_q[i], rdat, edges);
                update_model(adr, wdat, sel_q[i]);
            end else if (op == "R" || op == "M") begin
                if (op == "M" && !model.exists(adr)) begin
                    abort_run("model read of an address that was never written");
                end
                expv = (op == "M") ? model[adr] : exp_q[i];
                bus_access(1'b0, adr, '0, sel_q[i], rdat, edges);
                check_rdata(adr, expv, rdat);
            end else begin
                abort_run("unknown operation code in input file");
            end
            check_latency(adr, WAIT_CYCLES + 1, edges);
        end

        if (err_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "checks failed");
        end
    end

    // Ends a stuck run, armed once the access count is known
    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        abort_run("watchdog timeout: the run took longer than its access budget");
    end

endmodule

// File: dv/bus_input.txt
# op addr data sel expect, hex after op; W write, F random fill, R read vs expect, M read vs model
# sel matters to the memory only; unused columns hold 0
W 38000000 a5a5a5a5 f 00000000
W 38000004 12345678 f 00000000
W 380003fc deadbeef f 00000000
R 38000000 00000000 f a5a5a5a5
R 38000004 00000000 f 12345678
R 380003fc 00000000 f deadbeef
F 38000010 00000000 f 00000000
W 38000010 cafef00d 5 00000000
M 38000010 00000000 f 00000000
F 38000014 00000000 f 00000000
W 38000014 99887766 8 00000000
M 38000014 00000000 f 00000000
W 30000020 0000abcd f 00000000
W 30000048 fffe0001 f 00000000
W 30000010 00000040 f 00000000
W 38000020 ffffffff f 00000000
W 38000048 01010101 f 00000000
R 30000020 00000000 f 0000abcd
R 30000048 00000000 f fffe0001
R 30000010 00000000 f 00000040
W 30000000 ffffffff f 00000000
M 30000000 00000000 f 00000000
R 38000020 00000000 f ffffffff

// File: sources.f
source/user_area_pkg.sv
source/region_decoder.sv
source/user_sram.sv
source/fir_cfg_regs.sv
source/user_area_top.sv
dv/tb_clock_gen.sv
dv/user_area_asserts.sv
dv/tb_user_area.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the user area testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_user_area -Mdir obj_dir -o vsim_user_area -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vsim_user_area > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

# Verdict comes from the log
if grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1
